/* source/bitcore_pkg.sv */
package bitcore_pkg;

   // the bit counter is built for exactly 32 bits per pass
   localparam int XLEN = 32;

   typedef logic [XLEN-1:0]         word_t;
   typedef logic [2:0]              reg_addr_t;
   typedef logic signed [15:0]      imm_t;
   typedef logic [$clog2(XLEN)-1:0] bit_idx_t;

   // opcodes sit in instruction bits [3:0], anything not listed decodes to OP_NOP
   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_ADDI = 4'h2,
      OP_SLT  = 4'h3,
      OP_BEQ  = 4'h4,
      OP_BNE  = 4'h5,
      OP_OUT  = 4'h6,
      OP_NOP  = 4'hf
   } opcode_e;

   typedef struct packed {
      opcode_e   op;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      imm_t      imm;
      // SLT and the branches need a flag pass before the result pass
      logic      two_stage;
      logic      rd_write;
   } decode_t;

   typedef struct packed {
      logic     cnt_en;
      logic     init;
      logic     cnt0;
      logic     cnt_last;
      bit_idx_t bit_idx;
      logic     rf_wen;
      logic     pc_en;
      logic     jump;
   } ctrl_t;

endpackage

/* source/bitcore_decode.sv */
`timescale 1ns/1ps

module bitcore_decode (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_ibus_ack,
   input  bitcore_pkg::word_t   i_ibus_rdt,
   output bitcore_pkg::decode_t o_dec
);
   import bitcore_pkg::*;

   opcode_e op_next;

   // map the raw opcode field onto the enum, unused codes fall back to a no-op
   always_comb begin
      case (i_ibus_rdt[3:0])
         4'h0:    op_next = OP_ADD;
         4'h1:    op_next = OP_SUB;
         4'h2:    op_next = OP_ADDI;
         4'h3:    op_next = OP_SLT;
         4'h4:    op_next = OP_BEQ;
         4'h5:    op_next = OP_BNE;
         4'h6:    op_next = OP_OUT;
         default: op_next = OP_NOP;
      endcase
   end

   // opcode and its classification steer the control block
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_dec.op        <= OP_NOP;
         o_dec.two_stage <= 1'b0;
         o_dec.rd_write  <= 1'b0;
      end else if (i_ibus_ack) begin
         o_dec.op        <= op_next;
         // flag pass first for the compare-type ops
         o_dec.two_stage <= (op_next == OP_SLT) | (op_next == OP_BEQ) | (op_next == OP_BNE);
         o_dec.rd_write  <= (op_next == OP_ADD) | (op_next == OP_SUB) |
                            (op_next == OP_ADDI) | (op_next == OP_SLT);
      end
   end

   // register and immediate fields are only looked at during a pass
   always_ff @(posedge i_clk) begin
      if (i_ibus_ack) begin
         o_dec.rd  <= i_ibus_rdt[6:4];
         o_dec.rs1 <= i_ibus_rdt[9:7];
         o_dec.rs2 <= i_ibus_rdt[12:10];
         o_dec.imm <= i_ibus_rdt[31:16];
      end
   end

endmodule

/* source/bitcore_state.sv */
`timescale 1ns/1ps

module bitcore_state (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_ibus_ack,
   input  bitcore_pkg::decode_t i_dec,
   input  logic                 i_eq,
   input  logic                 i_lt,
   output logic                 o_ibus_cyc,
   output bitcore_pkg::ctrl_t   o_ctrl
);
   import bitcore_pkg::*;

   // upper three bits count normally, the low two bits live in a one-hot ring
   logic [2:0] cnt;
   logic [3:0] cnt_r;
   logic       cnt_en;
   logic       cnt_last;
   logic       init;
   logic       init_done;
   logic       stage_two_req;
   logic       pass_done;
   logic       jump;
   logic       take_branch;

   // the counter runs whenever a bit is circulating in the ring
   assign cnt_en   = |cnt_r;
   assign cnt_last = (cnt == 3'd7) & cnt_r[3];

   // a two-stage op sits in its flag pass until the first pass has completed
   assign init = i_dec.two_stage & ~init_done;

   // eq is complete during the last bit of the flag pass
   assign take_branch = ((i_dec.op == OP_BEQ) & i_eq) | ((i_dec.op == OP_BNE) & ~i_eq);

   always_comb begin
      o_ctrl.cnt_en   = cnt_en;
      o_ctrl.init     = init;
      o_ctrl.cnt0     = (cnt == 3'd0) & cnt_r[0];
      o_ctrl.cnt_last = cnt_last;
      // one-hot ring folded back into the two low index bits
      o_ctrl.bit_idx  = {cnt, cnt_r[3] | cnt_r[2], cnt_r[3] | cnt_r[1]};
      // nothing is written and pc holds during the flag pass
      o_ctrl.rf_wen   = cnt_en & ~init & i_dec.rd_write;
      o_ctrl.pc_en    = cnt_en & ~init;
      o_ctrl.jump     = jump;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt           <= 3'd0;
         cnt_r         <= 4'b0000;
         init_done     <= 1'b0;
         jump          <= 1'b0;
         stage_two_req <= 1'b0;
         pass_done     <= 1'b0;
         // the first fetch goes out straight after reset
         o_ibus_cyc    <= 1'b1;
      end else begin
         cnt <= cnt + {2'd0, cnt_r[3]};
         // a fetch acknowledge or the end of the idle cycle injects the start bit
         cnt_r <= {cnt_r[2:0], (cnt_r[3] & ~cnt_last) | i_ibus_ack | stage_two_req};
         // one idle cycle separates the flag pass from the result pass
         stage_two_req <= cnt_last & init;
         pass_done     <= cnt_last & ~init;
         if (cnt_last) begin
            init_done <= init;
            jump      <= init & take_branch;
         end
         // drop the request on acknowledge, raise it again once pc is updated
         if (i_ibus_ack) begin
            o_ibus_cyc <= 1'b0;
         end else if (pass_done) begin
            o_ibus_cyc <= 1'b1;
         end
      end
   end

   // fetching and executing never overlap
   assert property (@(posedge i_clk) disable iff (i_rst) !(o_ibus_cyc && cnt_en));
   assert property (@(posedge i_clk) disable iff (i_rst) $onehot0(cnt_r));

endmodule

/* source/bitcore_rf.sv */
`timescale 1ns/1ps

module bitcore_rf (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  bitcore_pkg::decode_t i_dec,
   input  bitcore_pkg::ctrl_t   i_ctrl,
   input  logic                 i_rd_bit,
   output logic                 o_rs1_bit,
   output logic                 o_rs2_bit
);
   import bitcore_pkg::*;

   word_t regs [8];
   word_t rs1_word;
   word_t rs2_word;
   logic  rd_wen;

   assign rs1_word = regs[i_dec.rs1];
   assign rs2_word = regs[i_dec.rs2];

   // register 0 always reads as zero whatever the array holds
   assign o_rs1_bit = (i_dec.rs1 != 3'd0) & rs1_word[i_ctrl.bit_idx];
   assign o_rs2_bit = (i_dec.rs2 != 3'd0) & rs2_word[i_ctrl.bit_idx];

   // writes to register 0 are dropped
   assign rd_wen = i_ctrl.rf_wen & (i_dec.rd != 3'd0);

   // each cycle the bit under the counter is read before it gets overwritten
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         // all registers start out at zero so software sees a defined state
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (rd_wen) begin
         regs[i_dec.rd][i_ctrl.bit_idx] <= i_rd_bit;
      end
   end

endmodule

/* source/bitcore_alu.sv */
`timescale 1ns/1ps

module bitcore_alu (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  bitcore_pkg::decode_t i_dec,
   input  bitcore_pkg::ctrl_t   i_ctrl,
   input  logic                 i_rs1_bit,
   input  logic                 i_rs2_bit,
   output logic                 o_rd_bit,
   output logic                 o_eq,
   output logic                 o_lt
);
   import bitcore_pkg::*;

   logic sub;
   logic imm_bit;
   logic b_raw;
   logic b_bit;
   logic carry_in;
   logic carry_r;
   logic sum;
   logic eq_r;
   logic lt_r;

   // all the compare-type ops subtract
   assign sub = (i_dec.op == OP_SUB) | i_dec.two_stage;

   // the immediate is sign extended above bit 15
   assign imm_bit = (i_ctrl.bit_idx > 5'd15) ? i_dec.imm[15] : i_dec.imm[i_ctrl.bit_idx[3:0]];
   assign b_raw   = (i_dec.op == OP_ADDI) ? imm_bit : i_rs2_bit;
   assign b_bit   = b_raw ^ sub;

   // carry starts at 1 for subtraction to finish the two's complement
   assign carry_in = i_ctrl.cnt0 ? sub : carry_r;
   assign sum      = i_rs1_bit ^ b_bit ^ carry_in;

   // eq folds in the current bit so it is complete at bit 31
   assign o_eq = (i_ctrl.cnt0 | eq_r) & ~(i_rs1_bit ^ b_raw);
   // at bit 31 differing signs decide directly, otherwise the difference sign does
   assign o_lt = (i_rs1_bit ^ b_raw) ? i_rs1_bit : sum;

   // SLT drops the flag from its first pass into bit 0 and clears the rest
   assign o_rd_bit = (i_dec.op == OP_SLT) ? (i_ctrl.cnt0 & lt_r) : sum;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry_r <= 1'b0;
         eq_r    <= 1'b0;
         lt_r    <= 1'b0;
      end else if (i_ctrl.cnt_en) begin
         carry_r <= (i_rs1_bit & b_bit) | (carry_in & (i_rs1_bit ^ b_bit));
         eq_r    <= o_eq;
         if (i_ctrl.cnt_last && i_ctrl.init) begin
            lt_r <= o_lt;
         end
      end
   end

endmodule

/* source/bitcore_pc.sv */
`timescale 1ns/1ps

module bitcore_pc #(
   parameter bitcore_pkg::word_t RESET_PC = '0
) (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  bitcore_pkg::decode_t i_dec,
   input  bitcore_pkg::ctrl_t   i_ctrl,
   output bitcore_pkg::word_t   o_pc
);
   import bitcore_pkg::*;

   word_t    pc_r;
   bit_idx_t off_idx;
   logic     imm_x4_bit;
   logic     addend;
   logic     carry_in;
   logic     carry_r;
   logic     sum;

   // imm times 4 is the immediate moved up two bit positions and sign extended
   assign off_idx    = i_ctrl.bit_idx - 5'd2;
   assign imm_x4_bit = (i_ctrl.bit_idx < 5'd2) ? 1'b0 :
                       (off_idx > 5'd15) ? i_dec.imm[15] : i_dec.imm[off_idx[3:0]];

   // the plain increment is a single set bit at position 2
   assign addend   = i_ctrl.jump ? imm_x4_bit : (i_ctrl.bit_idx == 5'd2);
   assign carry_in = ~i_ctrl.cnt0 & carry_r;
   assign sum      = pc_r[0] ^ addend ^ carry_in;

   // the pc rotates LSB first, the new bit comes in at the top
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc_r    <= RESET_PC;
         carry_r <= 1'b0;
      end else if (i_ctrl.pc_en) begin
         pc_r    <= {sum, pc_r[XLEN-1:1]};
         carry_r <= (pc_r[0] & addend) | (carry_in & (pc_r[0] ^ addend));
      end
   end

   // between passes the register holds the whole fetch address
   assign o_pc = pc_r;

endmodule

/* source/bitcore_outport.sv */
`timescale 1ns/1ps

module bitcore_outport (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  bitcore_pkg::decode_t i_dec,
   input  bitcore_pkg::ctrl_t   i_ctrl,
   input  logic                 i_rs1_bit,
   output logic                 o_out_stb,
   output bitcore_pkg::word_t   o_out_data
);
   import bitcore_pkg::*;

   logic is_out;

   assign is_out = i_ctrl.cnt_en & (i_dec.op == OP_OUT);

   // strobe marks the cycle right after the last bit has been shifted in
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_out_stb <= 1'b0;
      end else begin
         o_out_stb <= is_out & i_ctrl.cnt_last;
      end
   end

   // rs1 enters from the top so bit 0 ends up at the bottom after 32 shifts
   always_ff @(posedge i_clk) begin
      if (is_out) begin
         o_out_data <= {i_rs1_bit, o_out_data[XLEN-1:1]};
      end
   end

   assert property (@(posedge i_clk) disable iff (i_rst) o_out_stb |=> !o_out_stb);

endmodule

/* source/bitcore_top.sv */
`timescale 1ns/1ps

module bitcore_top #(
   parameter bitcore_pkg::word_t RESET_PC = '0
) (
   input  logic               i_clk,
   input  logic               i_rst,
   output logic               o_ibus_cyc,
   output bitcore_pkg::word_t o_ibus_adr,
   input  logic               i_ibus_ack,
   input  bitcore_pkg::word_t i_ibus_rdt,
   output logic               o_out_stb,
   output bitcore_pkg::word_t o_out_data
);
   import bitcore_pkg::*;

   decode_t dec;
   ctrl_t   ctrl;
   logic    rs1_bit;
   logic    rs2_bit;
   logic    rd_bit;
   logic    eq;
   logic    lt;

   bitcore_decode u_decode (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_dec      (dec)
   );

   // control block, owns the bit counter and the fetch request
   bitcore_state u_state (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_dec      (dec),
      .i_eq       (eq),
      .i_lt       (lt),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ctrl     (ctrl)
   );

   bitcore_rf u_rf (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_dec     (dec),
      .i_ctrl    (ctrl),
      .i_rd_bit  (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   bitcore_alu u_alu (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_dec     (dec),
      .i_ctrl    (ctrl),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .o_rd_bit  (rd_bit),
      .o_eq      (eq),
      .o_lt      (lt)
   );

   bitcore_pc #(
      .RESET_PC (RESET_PC)
   ) u_pc (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_dec  (dec),
      .i_ctrl (ctrl),
      .o_pc   (o_ibus_adr)
   );

   // the output port taps the same rs1 bit stream as the ALU
   bitcore_outport u_outport (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_dec      (dec),
      .i_ctrl     (ctrl),
      .i_rs1_bit  (rs1_bit),
      .o_out_stb  (o_out_stb),
      .o_out_data (o_out_data)
   );

endmodule

/* verification/bitcore_tb.sv */
`timescale 1ns/1ps

module bitcore_tb;

   localparam logic [31:0] RESET_PC  = 32'h0000_0200;
   localparam int          NUM_INSNS = 400;
   localparam int          TIMEOUT   = 200;

   // opcode field values of the instruction format
   localparam logic [3:0] OP_ADD  = 4'h0;
   localparam logic [3:0] OP_SUB  = 4'h1;
   localparam logic [3:0] OP_ADDI = 4'h2;
   localparam logic [3:0] OP_SLT  = 4'h3;
   localparam logic [3:0] OP_BEQ  = 4'h4;
   localparam logic [3:0] OP_BNE  = 4'h5;
   localparam logic [3:0] OP_OUT  = 4'h6;

   logic        i_clk;
   logic        i_rst;
   logic        i_ibus_ack;
   logic [31:0] i_ibus_rdt;
   logic        o_ibus_cyc;
   logic [31:0] o_ibus_adr;
   logic        o_out_stb;
   logic [31:0] o_out_data;

   logic [31:0] rng_state;
   logic [31:0] model_regs [8];
   logic [31:0] model_pc;
   int          error_count;
   int          timeout_count;
   int          stb_count;
   int          out_count;

   bitcore_top #(
      .RESET_PC (RESET_PC)
   ) u_dut (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_out_stb  (o_out_stb),
      .o_out_data (o_out_data)
   );

   initial begin
      i_clk = 1'b0;
   end

   always #50 i_clk = ~i_clk;

   // strobes are counted on the falling edge where the output has settled
   always @(negedge i_clk) begin
      if (!i_rst && o_out_stb) begin
         stb_count = stb_count + 1;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   // inputs change 1 ns after the rising edge and outputs are read at the same point
   task automatic next_cycle();
      @(posedge i_clk);
      #1;
   endtask

   task automatic wait_fetch();
      int n;
      n = 0;
      while (!o_ibus_cyc && n < TIMEOUT) begin
         next_cycle();
         n++;
      end
      assert (o_ibus_cyc) else begin
         timeout_count++;
         $display("timeout: no fetch request within %0d cycles at %0t", TIMEOUT, $time);
      end
   endtask

   task automatic wait_strobe();
      int n;
      n = 0;
      while (!o_out_stb && n < TIMEOUT) begin
         next_cycle();
         n++;
      end
      assert (o_out_stb) else begin
         timeout_count++;
         $display("timeout: OUT gave no strobe within %0d cycles at %0t", TIMEOUT, $time);
      end
   endtask

   // the fetch address must match the model and every finished OUT must have pulsed once
   task automatic check_fetch();
      assert (o_ibus_adr == model_pc) else begin
         error_count++;
         $display("error at %0t: o_ibus_adr = %h, expected %h", $time, o_ibus_adr, model_pc);
      end
      assert (stb_count == out_count) else begin
         error_count++;
         $display("error at %0t: o_out_stb pulses = %0d, expected %0d",
                  $time, stb_count, out_count);
      end
   endtask

   function automatic logic [31:0] random_insn();
      int          sel;
      int          off;
      logic [3:0]  op;
      logic [2:0]  rd;
      logic [2:0]  rs1;
      logic [2:0]  rs2;
      logic [15:0] imm;
      logic [31:0] coin;
      sel = int'(next_rand() % 16);
      rd  = 3'(next_rand());
      rs1 = 3'(next_rand());
      rs2 = 3'(next_rand());
      imm = 16'(next_rand());
      case (sel)
         0, 1, 2: op = OP_ADD;
         3:       op = OP_SUB;
         4, 5:    op = OP_ADDI;
         6, 7:    op = OP_SLT;
         8, 9:    op = OP_BEQ;
         10, 11:  op = OP_BNE;
         12, 13:  op = OP_OUT;
         default: op = 4'(int'(next_rand() % 9) + 7);
      endcase
      // doubling a register in place drives values toward overflow
      if (op == OP_ADD) begin
         coin = next_rand();
         if (coin[0]) begin
            rs1 = rd;
            rs2 = rd;
         end
      end
      // branches get short offsets, both signs, and equal operands half the time
      if (op == OP_BEQ || op == OP_BNE) begin
         off = int'(next_rand() % 17) - 8;
         imm = off[15:0];
         coin = next_rand();
         if (coin[0]) begin
            rs2 = rs1;
         end
      end
      return {imm, 3'(next_rand()), rs2, rs1, rd, op};
   endfunction

   // instruction-set model, one whole instruction per call
   task automatic execute_model(input logic [31:0] insn);
      logic [3:0]  op;
      logic [2:0]  rd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] res;
      logic        wr;
      op  = insn[3:0];
      rd  = insn[6:4];
      a   = model_regs[insn[9:7]];
      b   = model_regs[insn[12:10]];
      imm = {{16{insn[31]}}, insn[31:16]};
      wr  = 1'b1;
      res = '0;
      case (op)
         OP_ADD:  res = a + b;
         OP_SUB:  res = a - b;
         OP_ADDI: res = a + imm;
         OP_SLT:  res = {31'd0, ($signed(a) < $signed(b))};
         default: wr = 1'b0;
      endcase
      if ((op == OP_BEQ && a == b) || (op == OP_BNE && a != b)) begin
         model_pc = model_pc + (imm << 2);
      end else begin
         model_pc = model_pc + 32'd4;
      end
      // register 0 keeps its zero
      if (wr && rd != 3'd0) begin
         model_regs[rd] = res;
      end
   endtask

   initial begin
      logic [31:0] insn;
      logic [31:0] exp_out;
      int          delay;
      i_rst         = 1'b1;
      i_ibus_ack    = 1'b0;
      i_ibus_rdt    = '0;
      rng_state     = 32'h0675bb34;
      model_pc      = RESET_PC;
      error_count   = 0;
      timeout_count = 0;
      stb_count     = 0;
      out_count     = 0;
      for (int r = 0; r < 8; r++) begin
         model_regs[r] = '0;
      end
      repeat (8) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      for (int i = 0; i < NUM_INSNS && timeout_count == 0; i++) begin
         wait_fetch();
         if (timeout_count == 0) begin
            check_fetch();
            delay = int'(next_rand() % 4) + 1;
            // while the acknowledge is held back the request and address must stay put
            for (int d = 1; d < delay; d++) begin
               next_cycle();
               assert (o_ibus_cyc) else begin
                  error_count++;
                  $display("fetch request dropped before acknowledge at %0t", $time);
               end
               check_fetch();
            end
            insn       = random_insn();
            i_ibus_ack = 1'b1;
            i_ibus_rdt = insn;
            next_cycle();
            i_ibus_ack = 1'b0;
            i_ibus_rdt = '0;
            exp_out    = model_regs[insn[9:7]];
            execute_model(insn);
            if (insn[3:0] == OP_OUT) begin
               out_count++;
               wait_strobe();
               if (timeout_count == 0) begin
                  assert (o_out_data == exp_out) else begin
                     error_count++;
                     $display("error at %0t: o_out_data = %h, expected %h",
                              $time, o_out_data, exp_out);
                  end
               end
            end
         end
      end
      // the last instruction ends with the next fetch request
      if (timeout_count == 0) begin
         wait_fetch();
         if (timeout_count == 0) begin
            check_fetch();
         end
      end
      $display("%0d errors, %0d timeouts, %0d OUT strobes", error_count, timeout_count,
               stb_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* bitcore_top.f */
source/bitcore_pkg.sv
source/bitcore_decode.sv
source/bitcore_state.sv
source/bitcore_rf.sv
source/bitcore_alu.sv
source/bitcore_pc.sv
source/bitcore_outport.sv
source/bitcore_top.sv
verification/bitcore_tb.sv

/* Makefile */
TB = bitcore_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f bitcore_top.f --top-module bitcore_top

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f bitcore_top.f \
		--top-module $(TB) -o $(TB)
	./obj_dir/$(TB) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
